// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - rtl/cpu_pkg.sv
  - rtl/alu.sv
  - rtl/cpu_register_file.sv
  - rtl/cpu_port_interface.sv
  - rtl/cpu_memory_interface.sv
  - rtl/cpu_writeback.sv
  - rtl/cpu_control.sv
  - rtl/cpu_top.sv
  - target: simulation
    files:
      - verif/cpu_tb.sv

// ==== compile.f ====
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/cpu_register_file.sv
rtl/cpu_port_interface.sv
rtl/cpu_memory_interface.sv
rtl/cpu_writeback.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
verif/cpu_tb.sv

// ==== rtl/alu.sv ====
// --------------------
// ALU with add, subtract, logic ops and right shift,
// plus zero, carry and sign flags
// --------------------

module alu (
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	input  cpu_pkg::alu_op_e op,
	output cpu_pkg::word_t   result,
	output cpu_pkg::flags_t  flags
);
	import cpu_pkg::*;

	logic [16:0] wide;	// Result with carry bit
	logic [3:0]  shamt;

	assign shamt = b[3:0];

	always_comb begin
		wide = '0;
		case (op)
			ALU_ADD: wide = {1'b0, a} + {1'b0, b};
			ALU_SUB: wide = {1'b0, a} - {1'b0, b};	// Bit 16 is the borrow
			ALU_AND: wide = {1'b0, a & b};
			ALU_OR:  wide = {1'b0, a | b};
			ALU_XOR: wide = {1'b0, a ^ b};
			ALU_SHR: begin
				wide[15:0] = a >> shamt;
				if (shamt != 4'd0)
					wide[16] = a[shamt - 4'd1];	// Last bit out
			end
			default: wide = '0;
		endcase
	end

	assign result  = wide[15:0];
	assign flags.z = (wide[15:0] == 16'h0000);
	assign flags.c = wide[16];
	assign flags.s = wide[15];

endmodule

// ==== rtl/cpu_control.sv ====
// --------------------
// Instruction sequencer with program counter, instruction
// register and flags, decode and operand select
// --------------------

module cpu_control #(
	parameter int ADDRESS_BITS = 16
) (
	input  logic              CLK,
	input  logic              reset,

	output logic              fetch_req,
	output cpu_pkg::word_t    pc,
	output logic              data_req,
	output cpu_pkg::mem_req_t data,
	input  logic              mem_done,
	input  cpu_pkg::word_t    mem_rdata,

	output cpu_pkg::reg_sel_t ra_sel,
	output cpu_pkg::reg_sel_t rb_sel,
	input  cpu_pkg::word_t    ra_data,
	input  cpu_pkg::word_t    rb_data,

	output cpu_pkg::alu_op_e  alu_op,
	input  cpu_pkg::flags_t   alu_flags,

	output logic              port_cmd_rd,
	output logic              port_cmd_wr,

	output cpu_pkg::reg_sel_t rd,
	output cpu_pkg::wb_src_e  wb_src,
	output logic              reg_we,
	output cpu_pkg::word_t    imm,
	output logic              halted
);
	import cpu_pkg::*;

	state_e                    state_q;
	instr_t                    ir_q;
	logic [ADDRESS_BITS - 1:0] pc_q;
	flags_t                    flags_q;

	instr_t  cur;
	opcode_e op;
	logic    is_alu;
	logic    writes_reg;

	// While fetching, decode straight from the bus so port strobes land in EXECUTE
	assign cur        = (state_q == S_FETCH) ? instr_t'(mem_rdata) : ir_q;
	assign op         = cur.opcode;
	assign is_alu     = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHR};
	assign writes_reg = is_alu || (op inside {OP_LDI, OP_LD, OP_IN});

	assign ra_sel = cur.ra;
	assign rb_sel = (op inside {OP_ST, OP_OUT}) ? cur.rd : cur.rb;	// Store data from rd

	always_comb begin
		case (op)
			OP_SUB:  alu_op = ALU_SUB;
			OP_AND:  alu_op = ALU_AND;
			OP_OR:   alu_op = ALU_OR;
			OP_XOR:  alu_op = ALU_XOR;
			OP_SHR:  alu_op = ALU_SHR;
			default: alu_op = ALU_ADD;
		endcase
	end

	always_comb begin
		case (op)
			OP_LDI:  wb_src = WB_IMMEDIATE;
			OP_LD:   wb_src = WB_MEMORY;
			OP_IN:   wb_src = WB_PORT;
			default: wb_src = WB_ALU;
		endcase
	end

	assign fetch_req = (state_q == S_FETCH);
	assign pc        = word_t'(pc_q);
	assign data_req  = (state_q == S_MEMORY);
	assign data      = '{addr: ra_data, wr: (op == OP_ST),
		data: (op == OP_ST) ? rb_data : 16'h0000};

	// Registered by the port interface, so the strobe is seen in EXECUTE
	assign port_cmd_rd = (state_q == S_FETCH) && mem_done && (op == OP_IN);
	assign port_cmd_wr = (state_q == S_FETCH) && mem_done && (op == OP_OUT);

	assign rd     = ir_q.rd;
	assign reg_we = (state_q == S_WRITEBACK);
	assign imm    = {8'h00, ir_q.ra, ir_q.rb};
	assign halted = (state_q == S_HALTED);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state_q <= S_FETCH;
			pc_q    <= '0;
			flags_q <= '0;
		end else begin
			case (state_q)
				S_FETCH: if (mem_done) begin
					pc_q    <= pc_q + 1'b1;
					state_q <= S_EXECUTE;
				end
				S_EXECUTE: begin
					if (is_alu)
						flags_q <= alu_flags;	// Only ALU ops touch flags
					if (op == OP_JMP || (op == OP_JZ && flags_q.z))
						pc_q <= ra_data[ADDRESS_BITS - 1:0];
					if (op == OP_HALT)
						state_q <= S_HALTED;
					else if (op inside {OP_LD, OP_ST})
						state_q <= S_MEMORY;
					else if (writes_reg)
						state_q <= S_WRITEBACK;
					else
						state_q <= S_FETCH;	// OUT, jumps, unused codes
				end
				S_MEMORY: if (mem_done) begin
					state_q <= (op == OP_ST) ? S_FETCH : S_WRITEBACK;
				end
				S_WRITEBACK: state_q <= S_FETCH;
				default:     state_q <= S_HALTED;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state_q == S_FETCH && mem_done)
			ir_q <= instr_t'(mem_rdata);
	end

endmodule

// ==== rtl/cpu_memory_interface.sv ====
// --------------------
// Memory bus master, shares the bus between fetch
// and load/store with a valid/ready handshake
// --------------------

module cpu_memory_interface #(
	parameter int ADDRESS_BITS = 16
) (
	input  logic                      CLK,
	input  logic                      reset,

	input  logic                      fetch_req,
	input  cpu_pkg::word_t            pc,
	input  logic                      data_req,
	input  cpu_pkg::mem_req_t         data,
	output logic                      done,
	output cpu_pkg::word_t            rdata,

	output logic [ADDRESS_BITS - 1:0] memory_address,
	output cpu_pkg::word_t            memory_out,
	input  cpu_pkg::word_t            memory_in,
	output logic                      memory_wr,
	output logic                      memory_valid,
	input  logic                      memory_ready
);
	import cpu_pkg::*;

	mem_req_t req_q;	// Held stable until ready
	logic     busy_q;

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy_q <= 1'b0;
		end else if (busy_q) begin
			if (memory_ready)
				busy_q <= 1'b0;
		end else if (fetch_req || data_req) begin
			busy_q <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!busy_q) begin
			if (data_req)
				req_q <= data;
			else if (fetch_req)
				req_q <= '{addr: pc, data: '0, wr: 1'b0};
		end
	end

	assign memory_address = req_q.addr[ADDRESS_BITS - 1:0];
	assign memory_out     = req_q.data;
	assign memory_wr      = req_q.wr;
	assign memory_valid   = busy_q;

	assign done  = busy_q && memory_ready;	// Completing cycle
	assign rdata = memory_in;

endmodule

// ==== rtl/cpu_pkg.sv ====
// --------------------
// CPU package with the word and register types, the opcode, state,
// ALU and write-back enums, and the instruction, flag and memory
// request structs
// --------------------

package cpu_pkg;

	typedef logic [15:0] word_t;	// Machine word
	typedef logic [3:0]  reg_sel_t;	// One of sixteen registers

	// Top nibble of the instruction word
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_SHR  = 4'h5,
		OP_LDI  = 4'h6,
		OP_LD   = 4'h7,
		OP_ST   = 4'h8,
		OP_IN   = 4'h9,
		OP_OUT  = 4'ha,
		OP_JMP  = 4'hb,
		OP_JZ   = 4'hc,
		OP_HALT = 4'hf
	} opcode_e;

	typedef enum logic [2:0] {
		S_FETCH,
		S_EXECUTE,
		S_MEMORY,
		S_WRITEBACK,
		S_HALTED
	} state_e;

	// LDI takes {ra, rb} as an 8-bit immediate
	typedef struct packed {
		opcode_e  opcode;
		reg_sel_t rd;
		reg_sel_t ra;
		reg_sel_t rb;
	} instr_t;

	typedef struct packed {
		logic z;	// Zero
		logic c;	// Carry, borrow on SUB
		logic s;	// Sign
	} flags_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHR} alu_op_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEMORY, WB_PORT, WB_IMMEDIATE} wb_src_e;

	typedef struct packed {
		word_t addr;
		word_t data;	// Store data, zero on reads
		logic  wr;
	} mem_req_t;

endpackage

// ==== rtl/cpu_port_interface.sv ====
// --------------------
// I/O port bus register with address, data
// and one-cycle read and write strobes
// --------------------

module cpu_port_interface (
	input  logic           CLK,
	input  logic           reset,
	input  logic           cmd_rd,
	input  logic           cmd_wr,
	input  cpu_pkg::word_t address,
	input  cpu_pkg::word_t data,
	output cpu_pkg::word_t port_address,
	output cpu_pkg::word_t port_out,
	output logic           port_rd,
	output logic           port_wr
);

	always_ff @(posedge CLK) begin
		if (reset) begin
			port_rd <= 1'b0;
			port_wr <= 1'b0;
		end else begin
			port_rd <= cmd_rd;	// High for one cycle per command
			port_wr <= cmd_wr;
		end
	end

	always_ff @(posedge CLK) begin
		if (cmd_rd || cmd_wr) begin
			port_address <= address;
			port_out     <= data;
		end
	end

endmodule

// ==== rtl/cpu_register_file.sv ====
// --------------------
// Register file, sixteen words,
// two read ports and one write port
// --------------------

module cpu_register_file (
	input  logic              CLK,
	input  logic              reset,
	input  cpu_pkg::reg_sel_t ra_sel,
	input  cpu_pkg::reg_sel_t rb_sel,
	output cpu_pkg::word_t    ra_data,
	output cpu_pkg::word_t    rb_data,
	input  cpu_pkg::reg_sel_t wr_sel,
	input  cpu_pkg::word_t    wr_data,
	input  logic              wr_en
);
	import cpu_pkg::*;

	word_t regs_q [16];

	assign ra_data = regs_q[ra_sel];	// Combinational reads
	assign rb_data = regs_q[rb_sel];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs_q[i] <= '0;
		end else if (wr_en) begin
			regs_q[wr_sel] <= wr_data;
		end
	end

endmodule

// ==== rtl/cpu_top.sv ====
// --------------------
// CPU top level with the sequencer, register file, ALU,
// port interface, memory interface and write-back
// --------------------

module cpu_top #(
	parameter int ADDRESS_BITS = 16
) (
	input  logic                      CLK,
	input  logic                      reset,

	output logic [ADDRESS_BITS - 1:0] memory_address,
	output cpu_pkg::word_t            memory_out,
	input  cpu_pkg::word_t            memory_in,
	output logic                      memory_wr,
	output logic                      memory_valid,	// Request pending
	input  logic                      memory_ready,	// Completes the transfer

	output cpu_pkg::word_t            port_address,
	output cpu_pkg::word_t            port_out,
	input  cpu_pkg::word_t            port_in,
	output logic                      port_rd,
	output logic                      port_wr,

	output logic                      halted
);
	import cpu_pkg::*;

	logic     fetch_req;
	word_t    pc;
	logic     data_req;
	mem_req_t data;
	logic     mem_done;
	word_t    mem_rdata;

	reg_sel_t ra_sel;
	reg_sel_t rb_sel;
	word_t    ra_data;
	word_t    rb_data;

	alu_op_e  alu_op;
	word_t    alu_result;
	flags_t   alu_flags;

	logic     port_cmd_rd;
	logic     port_cmd_wr;

	reg_sel_t rd;
	wb_src_e  wb_src;
	logic     reg_we;
	word_t    imm;
	reg_sel_t wr_sel;
	word_t    wr_data;
	logic     wr_en;

	cpu_control #(.ADDRESS_BITS(ADDRESS_BITS)) ctl0 (
		.CLK, .reset,
		.fetch_req, .pc, .data_req, .data, .mem_done, .mem_rdata,
		.ra_sel, .rb_sel, .ra_data, .rb_data,
		.alu_op, .alu_flags,
		.port_cmd_rd, .port_cmd_wr,
		.rd, .wb_src, .reg_we, .imm,
		.halted
	);

	cpu_register_file reg0 (
		.CLK, .reset,
		.ra_sel, .rb_sel, .ra_data, .rb_data,
		.wr_sel, .wr_data, .wr_en
	);

	alu alu0 (
		.a(ra_data), .b(rb_data), .op(alu_op),
		.result(alu_result), .flags(alu_flags)
	);

	// ra gives the port address, rd the output data
	cpu_port_interface prt0 (
		.CLK, .reset,
		.cmd_rd(port_cmd_rd), .cmd_wr(port_cmd_wr),
		.address(ra_data), .data(rb_data),
		.port_address, .port_out, .port_rd, .port_wr
	);

	cpu_memory_interface #(.ADDRESS_BITS(ADDRESS_BITS)) mem0 (
		.CLK, .reset,
		.fetch_req, .pc, .data_req, .data,
		.done(mem_done), .rdata(mem_rdata),
		.memory_address, .memory_out, .memory_in,
		.memory_wr, .memory_valid, .memory_ready
	);

	cpu_writeback wb0 (
		.CLK, .mem_done,
		.wb_src, .rd, .reg_we,
		.alu_result, .load_data(mem_rdata), .port_in, .imm,
		.wr_sel, .wr_data, .wr_en
	);

endmodule

// ==== rtl/cpu_writeback.sv ====
// --------------------
// Write-back select of ALU result, load data,
// port input or immediate into the register write port
// --------------------

module cpu_writeback (
	input  logic              CLK,
	input  logic              mem_done,
	input  cpu_pkg::wb_src_e  wb_src,
	input  cpu_pkg::reg_sel_t rd,
	input  logic              reg_we,
	input  cpu_pkg::word_t    alu_result,
	input  cpu_pkg::word_t    load_data,
	input  cpu_pkg::word_t    port_in,
	input  cpu_pkg::word_t    imm,
	output cpu_pkg::reg_sel_t wr_sel,
	output cpu_pkg::word_t    wr_data,
	output logic              wr_en
);
	import cpu_pkg::*;

	word_t load_q;

	// Last completed transfer, which is the load by WRITEBACK
	always_ff @(posedge CLK) begin
		if (mem_done)
			load_q <= load_data;
	end

	always_comb begin
		case (wb_src)
			WB_MEMORY:    wr_data = load_q;
			WB_PORT:      wr_data = port_in;	// Sampled the cycle after port_rd
			WB_IMMEDIATE: wr_data = imm;
			default:      wr_data = alu_result;
		endcase
	end

	assign wr_sel = rd;
	assign wr_en  = reg_we;

endmodule

// ==== verif/cpu_tb.sv ====
// --------------------
// Testbench for cpu_top with random programs, a bus memory,
// an instruction-set model, port checks and a watchdog
// --------------------

module cpu_tb;
	import cpu_pkg::*;

	localparam int ADDR_BITS = 8;
	localparam int MEM_WORDS = 1 << ADDR_BITS;
	localparam int PROGRAMS  = 4;
	localparam int BODY_LEN  = 24;
	localparam int MAX_WAIT  = 3;

	logic                   CLK;
	logic                   reset;
	logic [ADDR_BITS - 1:0] memory_address;
	word_t                  memory_out;
	word_t                  memory_in;
	logic                   memory_wr;
	logic                   memory_valid;
	logic                   memory_ready;
	word_t                  port_address;
	word_t                  port_out;
	word_t                  port_in;
	logic                   port_rd;
	logic                   port_wr;
	logic                   halted;

	word_t       mem [MEM_WORDS];	// Memory seen by the bus
	word_t       model_mem [MEM_WORDS];
	word_t       in_vals [$];	// Port input per IN, in order
	mem_req_t    exp_mem [$];
	mem_req_t    exp_port [$];	// addr holds the port address
	mem_req_t    exp_req;
	mem_req_t    exp_out;
	mem_req_t    held;
	logic [31:0] prog_state;
	logic [31:0] bus_state;
	int          in_idx;
	int          exp_reads;	// IN count of the model
	int          wait_cnt;
	logic        pending;
	time         deadline;

	cpu_top #(.ADDRESS_BITS(ADDR_BITS)) uut (
		.CLK, .reset,
		.memory_address, .memory_out, .memory_in,
		.memory_wr, .memory_valid, .memory_ready,
		.port_address, .port_out, .port_in, .port_rd, .port_wr,
		.halted
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int rand_below(input int n);
		prog_state = xorshift32(prog_state);
		return int'(prog_state % n);
	endfunction

	function automatic word_t encode(input opcode_e op, input int rd, input int ra, input int rb);
		return {op, 4'(rd), 4'(ra), 4'(rb)};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED at %0t: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic load_word(input int addr, input word_t w);
		mem[addr]       = w;
		model_mem[addr] = w;
	endtask

	task automatic fill_memory;
		for (int a = 0; a < MEM_WORDS; a++)
			load_word(a, word_t'(a * 40503) ^ 16'ha5c3);	// Differs per address
		in_vals.delete();
		for (int i = 0; i < 32; i++) begin
			prog_state = xorshift32(prog_state);
			in_vals.push_back(prog_state[15:0]);
		end
	endtask

	task automatic build_random_program;
		int      pc;
		int      rd;
		opcode_e op;
		opcode_e pool [11] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHR,
			OP_LDI, OP_LD, OP_ST, OP_IN, OP_OUT};
		fill_memory();
		for (pc = 0; pc < 16; pc++) begin
			if (pc >= 14)
				load_word(pc, encode(OP_LDI, pc, 4'hc + rand_below(4), rand_below(16)));	// Data region
			else
				load_word(pc, encode(OP_LDI, pc, rand_below(16), rand_below(16)));
		end
		for (int i = 0; i < BODY_LEN; i++) begin
			op = pool[rand_below(11)];
			rd = rand_below(14);	// r14 and r15 stay pointers
			if (op inside {OP_LD, OP_ST})
				load_word(pc, encode(op, rd, 14 + rand_below(2), 0));
			else
				load_word(pc, encode(op, rd, rand_below(16), rand_below(16)));
			pc++;
		end
		for (int r = 0; r < 16; r++) begin
			load_word(pc, encode(OP_OUT, r, rand_below(16), 0));
			pc++;
		end
		load_word(pc, encode(OP_HALT, 0, 0, 0));
	endtask

	task automatic build_jump_program;
		fill_memory();
		load_word(0, encode(OP_LDI, 1, 0, 6));	// Target of the taken JZ
		load_word(1, encode(OP_LDI, 2, 0, 0));
		load_word(2, encode(OP_SUB, 3, 2, 2));	// Sets z
		load_word(3, encode(OP_JZ, 0, 1, 0));
		load_word(4, encode(OP_OUT, 2, 2, 0));
		load_word(5, encode(OP_HALT, 0, 0, 0));
		load_word(6, encode(OP_LDI, 4, 0, 1));
		load_word(7, encode(OP_ADD, 5, 4, 4));	// Clears z
		load_word(8, encode(OP_LDI, 6, 0, 12));
		load_word(9, encode(OP_JZ, 0, 6, 0));	// Falls through
		load_word(10, encode(OP_JMP, 0, 6, 0));
		load_word(11, encode(OP_OUT, 4, 4, 0));
		load_word(12, encode(OP_OUT, 5, 4, 0));
		load_word(13, encode(OP_HALT, 0, 0, 0));
	endtask

	// Runs the program and queues every bus access and port write it should make
	task automatic run_model(output int executed);
		word_t  regs [16];
		instr_t iw;
		word_t  a;
		word_t  b;
		word_t  res;
		int     pc;
		int     k;
		logic   z;
		logic   done;
		exp_mem.delete();
		exp_port.delete();
		foreach (regs[i])
			regs[i] = '0;
		pc       = 0;
		k        = 0;
		z        = 1'b0;
		done     = 1'b0;
		executed = 0;
		while (!done && executed < 1000) begin
			exp_mem.push_back(mem_req_t'{addr: word_t'(pc), data: '0, wr: 1'b0});
			iw = instr_t'(model_mem[pc]);
			pc = (pc + 1) % MEM_WORDS;
			executed++;
			a   = regs[iw.ra];
			b   = regs[iw.rb];
			res = '0;
			case (iw.opcode)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				OP_SHR:  res = a >> b[3:0];
				OP_LDI:  regs[iw.rd] = {8'h00, iw.ra, iw.rb};
				OP_LD: begin
					exp_mem.push_back(mem_req_t'{addr: a, data: '0, wr: 1'b0});
					regs[iw.rd] = model_mem[a[ADDR_BITS - 1:0]];
				end
				OP_ST: begin
					exp_mem.push_back(mem_req_t'{addr: a, data: regs[iw.rd], wr: 1'b1});
					model_mem[a[ADDR_BITS - 1:0]] = regs[iw.rd];
				end
				OP_IN: begin
					regs[iw.rd] = in_vals[k];
					k++;
				end
				OP_OUT:  exp_port.push_back(mem_req_t'{addr: a, data: regs[iw.rd], wr: 1'b1});
				OP_JMP:  pc = int'(a[ADDR_BITS - 1:0]);
				OP_JZ:   if (z) pc = int'(a[ADDR_BITS - 1:0]);
				OP_HALT: done = 1'b1;
				default: ;
			endcase
			if (iw.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHR}) begin
				regs[iw.rd] = res;
				z           = (res == 16'h0000);
			end
		end
		exp_reads = k;
	endtask

	// Memory responder, port input source and bus checks
	always @(posedge CLK) begin
		bus_state = xorshift32(bus_state);
		port_in <= bus_state[31:16];	// Noise unless a read is answered
		if (reset) begin
			memory_ready <= 1'b0;
			pending  = 1'b0;
			in_idx   = 0;
			wait_cnt = int'(bus_state % (MAX_WAIT + 1));
		end else begin
			if (port_rd) begin
				if (in_idx >= in_vals.size()) begin
					abort_run("Port read with no input value left");
				end else begin
					port_in <= in_vals[in_idx];
					in_idx++;
				end
			end
			if (port_wr) begin
				if (exp_port.size() == 0) begin
					abort_run("Port write that the model does not predict");
				end else begin
					exp_out = exp_port.pop_front();
					check_equal(port_address, exp_out.addr, "port address");
					check_equal(port_out, exp_out.data, "port data");
				end
			end
			if (memory_valid) begin
				if (pending) begin
					check_equal(memory_address, held.addr, "address held while waiting");
					check_equal(memory_out, held.data, "data held while waiting");
					check_equal(memory_wr, held.wr, "write flag held while waiting");
				end
				held    = mem_req_t'{addr: word_t'(memory_address), data: memory_out,
					wr: memory_wr};
				pending = !memory_ready;
				if (memory_ready) begin
					if (exp_mem.size() == 0) begin
						abort_run("Memory request that the model does not predict");
					end else begin
						exp_req = exp_mem.pop_front();
						check_equal(memory_address, exp_req.addr[ADDR_BITS - 1:0],
							"memory address");
						check_equal(memory_wr, exp_req.wr, "memory write flag");
						if (memory_wr) begin
							check_equal(memory_out, exp_req.data, "store data");
							mem[memory_address] = memory_out;
						end
						memory_ready <= 1'b0;
						memory_in    <= bus_state[15:0];
						wait_cnt = int'(bus_state % (MAX_WAIT + 1));
					end
				end else if (wait_cnt == 0) begin
					memory_ready <= 1'b1;
					memory_in    <= mem[memory_address];
				end else begin
					wait_cnt--;
				end
			end
		end
	end

	always @(posedge CLK) begin
		if (!reset && $time > deadline)
			abort_run("Watchdog expired, the CPU looks hung");
	end

	initial begin
		int executed;
		reset        = 1'b1;
		memory_in    = '0;
		memory_ready = 1'b0;
		port_in      = '0;
		prog_state   = 32'hc221;
		bus_state    = 32'hc221;
		deadline     = 0;
		for (int p = 0; p <= PROGRAMS; p++) begin
			@(posedge CLK);
			reset <= 1'b1;
			if (p < PROGRAMS)
				build_random_program();
			else
				build_jump_program();
			run_model(executed);
			// 4 cycles per instruction plus two slowest transfers, doubled
			deadline = $time + 100 * (3 + 2 * (executed * (4 + 2 * (MAX_WAIT + 2)) + 16));
			repeat (3) @(posedge CLK);
			check_equal(memory_valid, 1'b0, "memory_valid after reset");
			check_equal(port_rd, 1'b0, "port_rd after reset");
			check_equal(port_wr, 1'b0, "port_wr after reset");
			check_equal(halted, 1'b0, "halted after reset");
			reset <= 1'b0;
			while (halted !== 1'b1)
				@(posedge CLK);
			check_equal(exp_mem.size(), 0, "memory accesses left at halt");
			check_equal(exp_port.size(), 0, "port writes left at halt");
			check_equal(in_idx, exp_reads, "port reads at halt");
			repeat (8) begin
				@(posedge CLK);
				check_equal(memory_valid, 1'b0, "memory request after halt");
				check_equal(halted, 1'b1, "halted stays high");
			end
		end
		$display("test passed");
		$finish;
	end

endmodule
